// ==== flist.f ====
+incdir+sim
common/iq_pkg.sv
issue_queue/iq_select.sv
issue_queue/issue_queue.sv
hw/prf.sv
hw/reg_read.sv
hw/int_alu.sv
hw/int_issue_top.sv
sim/tb_int_issue.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -f flist.f --top-module tb_int_issue
out=$(./obj_dir/Vtb_int_issue)
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1

// ==== sim/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// registers from CONST_BASE up keep their setup values for the whole run
localparam int CONST_BASE = 48;
localparam logic [1:0] ST_FREE = 2'd0;
localparam logic [1:0] ST_PEND = 2'd1;
localparam logic [1:0] ST_LIVE = 2'd2;

// value each register gets from its current producer
xdata_t model_val [PREG_NUM];
logic [1:0] reg_state [PREG_NUM];
// queued or in-flight ops that still read the register
int readers [PREG_NUM];
logic [PREG_NUM-1:0] exp_wb;
preg_idx_t prod_src [PREG_NUM][NUM_SRCS];
int outstanding;

function automatic xdata_t eval_op(input alu_op_t op, input xdata_t a, input xdata_t b);
    xdata_t res;
    case (op)
        ALU_ADD: res = a + b;
        ALU_SUB: res = a + ~b + 32'd1;
        ALU_AND: res = a & b;
        ALU_OR:  res = a | b;
        ALU_XOR: res = a ^ b;
        ALU_SLL: res = a << b[4:0];
        ALU_SRL: res = a >> b[4:0];
        default: res = '0;
    endcase
    return res;
endfunction

// bookkeeping for an op that will write back
task automatic record_op(input exe_info_t info);
    model_val[info.iprd] = eval_op(info.op, model_val[info.iprs0], model_val[info.iprs1]);
    reg_state[info.iprd] = ST_PEND;
    exp_wb[info.iprd] = 1'b1;
    prod_src[info.iprd][0] = info.iprs0;
    prod_src[info.iprd][1] = info.iprs1;
    readers[info.iprs0]++;
    readers[info.iprs1]++;
    outstanding++;
endtask

task automatic check_wb(input int p, input wb_t wb);
    if (wb.vld) begin
        if (!exp_wb[wb.idx]) begin
            $display("time %0t: port %0d wrote register %0d, which has no producer in flight",
                     $time, p, wb.idx);
            other_errs++;
        end else begin
            if (wb.data !== model_val[wb.idx]) begin
                $display("CHECK FAILED time %0t o_wb[%0d].data (reg %0d) got %h expected %h",
                         $time, p, wb.idx, wb.data, model_val[wb.idx]);
                val_errs++;
            end
            exp_wb[wb.idx] = 1'b0;
            reg_state[wb.idx] = ST_LIVE;
            readers[prod_src[wb.idx][0]]--;
            readers[prod_src[wb.idx][1]]--;
            outstanding--;
        end
    end
endtask

`endif

// ==== sim/tb_int_issue.sv ====
`timescale 1ns/1ps

module tb_int_issue import iq_pkg::*; ();

    localparam int OP_TOTAL = 400;
    localparam int CYCLE_LIMIT = OP_TOTAL * 20 + 200;

    logic clk;
    logic rst;
    logic [PORT_NUM-1:0] enq_vld;
    exe_info_t enq_info [PORT_NUM];
    src_vec_t enq_rdy [PORT_NUM];
    logic enq_ready;
    wakeup_t ld_alloc;
    wakeup_t ld_spec;
    wb_t ld_wb;
    wb_t wb_out [PORT_NUM];

    int val_errs;
    int other_errs;
    logic [31:0] lfsr;
    int ops_gen;
    int cycles;
    logic held;
    logic timed_out;
    // one load in flight at a time
    logic ld_busy;
    preg_idx_t ld_reg;
    int ld_cnt;
    int ld_wb_at;
    preg_idx_t last_dest;

    `include "tb_model.svh"

    int_issue_top dut_i (
        .clk (clk), .rst (rst),
        .i_enq_vld (enq_vld), .i_enq_info (enq_info), .i_enq_rdy (enq_rdy),
        .o_enq_ready (enq_ready),
        .i_ld_alloc (ld_alloc), .i_ld_spec (ld_spec), .i_ld_wb (ld_wb),
        .o_wb (wb_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] res;
        logic fb;
        res = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            res = {res[30:0], fb};
        end
        return res;
    endfunction

    function automatic int free_count();
        int n;
        n = 0;
        for (int r = 0; r < CONST_BASE; r++) begin
            if (reg_state[r] == ST_FREE) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic int find_free();
        int start;
        int r;
        int hit;
        start = int'(rand_bits(6)) % CONST_BASE;
        hit = -1;
        for (int k = 0; k < CONST_BASE; k++) begin
            r = (start + k) % CONST_BASE;
            if (hit < 0 && reg_state[r] == ST_FREE) begin
                hit = r;
            end
        end
        return hit;
    endfunction

    function automatic preg_idx_t pick_src();
        int r;
        // the newest producer half of the time, for dependent chains
        if (rand_bits(1) == 1 && reg_state[last_dest] != ST_FREE) begin
            return last_dest;
        end
        r = int'(rand_bits(6));
        while (reg_state[r] == ST_FREE) begin
            r = (r + 1) % PREG_NUM;
        end
        return preg_idx_t'(r);
    endfunction

    // recycle one written register that nobody reads any more
    task automatic free_one();
        int start;
        int r;
        logic done;
        if (free_count() < 12) begin
            start = int'(rand_bits(6)) % CONST_BASE;
            done = 1'b0;
            for (int k = 0; k < CONST_BASE; k++) begin
                r = (start + k) % CONST_BASE;
                if (!done && reg_state[r] == ST_LIVE && readers[r] == 0) begin
                    reg_state[r] = ST_FREE;
                    done = 1'b1;
                end
            end
        end
    endtask

    task automatic make_op(input int p);
        exe_info_t info;
        logic [2:0] code;
        int d;
        info.rd_wen = (rand_bits(3) != 0);
        code = 3'(rand_bits(8) % 7);
        info.op = alu_op_t'(code);
        enq_vld[p] = 1'b0;
        if (info.rd_wen) begin
            d = find_free();
            if (d >= 0) begin
                info.iprs0 = pick_src();
                info.iprs1 = pick_src();
                info.iprd = preg_idx_t'(d);
                record_op(info);
                last_dest = info.iprd;
                enq_info[p] = info;
                enq_vld[p] = 1'b1;
                ops_gen++;
            end
        end else begin
            // no writeback to observe, so only fixed registers are read
            info.iprs0 = preg_idx_t'(CONST_BASE + int'(rand_bits(4)));
            info.iprs1 = preg_idx_t'(CONST_BASE + int'(rand_bits(4)));
            info.iprd = '0;
            enq_info[p] = info;
            enq_vld[p] = 1'b1;
            ops_gen++;
        end
    endtask

    task automatic step_load();
        int d;
        if (ld_busy) begin
            ld_cnt++;
            if (ld_cnt == 1) begin
                ld_spec.vld = 1'b1;
                ld_spec.idx = ld_reg;
            end
            if (ld_cnt == ld_wb_at) begin
                ld_wb.vld = 1'b1;
                ld_wb.idx = ld_reg;
                ld_wb.data = model_val[ld_reg];
                reg_state[ld_reg] = ST_LIVE;
                ld_busy = 1'b0;
            end
        end else if (ops_gen < OP_TOTAL && rand_bits(3) == 0) begin
            d = find_free();
            if (d >= 0) begin
                ld_reg = preg_idx_t'(d);
                ld_alloc.vld = 1'b1;
                ld_alloc.idx = ld_reg;
                model_val[ld_reg] = rand_bits(32);
                reg_state[ld_reg] = ST_PEND;
                last_dest = ld_reg;
                ld_busy = 1'b1;
                ld_cnt = 0;
                // data 2 cycles after the wakeup means the speculation held
                ld_wb_at = 3 + int'(rand_bits(8) % 5);
            end
        end
    endtask

    task automatic drive_cycle();
        ld_alloc = '0;
        ld_spec = '0;
        ld_wb = '0;
        for (int p = 0; p < PORT_NUM; p++) begin
            check_wb(p, wb_out[p]);
        end
        step_load();
        // a refused group stays on the bus unchanged
        if (!held) begin
            for (int p = 0; p < PORT_NUM; p++) begin
                if (ops_gen < OP_TOTAL && rand_bits(1) == 1) begin
                    make_op(p);
                end else begin
                    enq_vld[p] = 1'b0;
                end
            end
        end
        for (int p = 0; p < PORT_NUM; p++) begin
            enq_rdy[p] = {reg_state[enq_info[p].iprs1] == ST_LIVE,
                          reg_state[enq_info[p].iprs0] == ST_LIVE};
        end
        held = (|enq_vld) && !enq_ready;
        free_one();
    endtask

    task automatic load_registers();
        for (int r = 0; r < PREG_NUM; r++) begin
            @(posedge clk);
            #1;
            for (int p = 0; p < PORT_NUM; p++) begin
                check_wb(p, wb_out[p]);
            end
            model_val[r] = rand_bits(32);
            reg_state[r] = ST_LIVE;
            ld_wb.vld = 1'b1;
            ld_wb.idx = preg_idx_t'(r);
            ld_wb.data = model_val[r];
        end
        @(posedge clk);
        #1;
        ld_wb = '0;
    endtask

    initial begin
        lfsr = 32'h73f3_ae19;
        val_errs = 0;
        other_errs = 0;
        ops_gen = 0;
        cycles = 0;
        held = 1'b0;
        timed_out = 1'b0;
        ld_busy = 1'b0;
        ld_reg = '0;
        ld_cnt = 0;
        ld_wb_at = 0;
        last_dest = preg_idx_t'(CONST_BASE);
        outstanding = 0;
        exp_wb = '0;
        for (int r = 0; r < PREG_NUM; r++) begin
            readers[r] = 0;
            reg_state[r] = ST_FREE;
            model_val[r] = '0;
        end
        rst = 1'b1;
        enq_vld = '0;
        for (int p = 0; p < PORT_NUM; p++) begin
            enq_info[p] = '0;
            enq_rdy[p] = '0;
        end
        ld_alloc = '0;
        ld_spec = '0;
        ld_wb = '0;

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        if (enq_ready !== 1'b1) begin
            $display("CHECK FAILED time %0t o_enq_ready got %b expected 1", $time, enq_ready);
            val_errs++;
        end
        for (int p = 0; p < PORT_NUM; p++) begin
            if (wb_out[p].vld !== 1'b0) begin
                $display("CHECK FAILED time %0t o_wb[%0d].vld got %b expected 0",
                         $time, p, wb_out[p].vld);
                val_errs++;
            end
        end

        load_registers();

        while ((ops_gen < OP_TOTAL || held || ld_busy || outstanding != 0) && !timed_out) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                timed_out = 1'b1;
            end else begin
                drive_cycle();
            end
        end

        if (timed_out) begin
            $display("timeout: run passed %0d cycles with %0d writebacks still missing",
                     CYCLE_LIMIT, outstanding);
            other_errs++;
        end else begin
            // quiet tail, any late writeback here is a duplicate
            enq_vld = '0;
            ld_alloc = '0;
            ld_spec = '0;
            ld_wb = '0;
            repeat (20) begin
                @(posedge clk);
                #1;
                for (int p = 0; p < PORT_NUM; p++) begin
                    check_wb(p, wb_out[p]);
                end
            end
            if (outstanding != 0 || exp_wb != '0) begin
                $display("%0d operations never wrote back", outstanding);
                other_errs++;
            end
        end

        $display("errors: %0d value mismatches, %0d other failures (%0d ops, %0d cycles)",
                 val_errs, other_errs, ops_gen, cycles);
        if (val_errs == 0 && other_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== hw/int_issue_top.sv ====
`timescale 1ns/1ps

module int_issue_top import iq_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [PORT_NUM-1:0] i_enq_vld,
    input  exe_info_t           i_enq_info [PORT_NUM],
    input  src_vec_t            i_enq_rdy [PORT_NUM],
    output logic                o_enq_ready,
    input  wakeup_t             i_ld_alloc,
    input  wakeup_t             i_ld_spec,
    input  wb_t                 i_ld_wb,
    output wb_t                 o_wb [PORT_NUM]
);

    logic [PORT_NUM-1:0] iss_vld;
    logic [PORT_NUM-1:0] fin_vec;
    logic [PORT_NUM-1:0] rpl_vec;
    iq_idx_t iss_idx [PORT_NUM];
    iq_idx_t fb_idx [PORT_NUM];
    exe_info_t iss_info [PORT_NUM];
    preg_idx_t prf_rd_idx [RD_NUM];
    xdata_t prf_data [RD_NUM];
    logic [RD_NUM-1:0] prf_written;
    wb_t alu_fwd [PORT_NUM];
    exe_op_t exe_op [PORT_NUM];
    // ALU writebacks then the load
    wb_t wb_all [WB_NUM];
    // new producers at enqueue, then the load allocation
    wakeup_t prf_clr [WB_NUM];

    always_comb begin
        for (int p = 0; p < PORT_NUM; p++) begin
            wb_all[p] = o_wb[p];
            prf_clr[p].vld = i_enq_vld[p] && o_enq_ready && i_enq_info[p].rd_wen;
            prf_clr[p].idx = i_enq_info[p].iprd;
        end
        wb_all[PORT_NUM] = i_ld_wb;
        prf_clr[PORT_NUM] = i_ld_alloc;
    end

    // internal wakeup is consumed inside the queue
    issue_queue iq_i (
        .clk (clk), .rst (rst),
        .i_enq_vld (i_enq_vld), .i_enq_info (i_enq_info), .i_enq_rdy (i_enq_rdy),
        .o_enq_ready (o_enq_ready),
        .o_iss_vld (iss_vld), .o_iss_idx (iss_idx), .o_iss_info (iss_info),
        .i_fin_vec (fin_vec), .i_rpl_vec (rpl_vec), .i_fb_idx (fb_idx),
        .o_int_wakeup (), .i_ld_spec (i_ld_spec), .i_wb (wb_all)
    );

    reg_read rr_i (
        .clk (clk), .rst (rst),
        .i_iss_vld (iss_vld), .i_iss_idx (iss_idx), .i_iss_info (iss_info),
        .o_fin_vec (fin_vec), .o_rpl_vec (rpl_vec), .o_fb_idx (fb_idx),
        .o_prf_rd_idx (prf_rd_idx), .i_prf_data (prf_data), .i_prf_written (prf_written),
        .i_alu_fwd (alu_fwd), .i_alu_wb (o_wb), .i_ld_wb (i_ld_wb), .o_exe_op (exe_op)
    );

    prf prf_i (
        .clk (clk), .rst (rst),
        .i_rd_idx (prf_rd_idx), .o_rd_data (prf_data), .o_rd_written (prf_written),
        .i_wr (wb_all), .i_clr (prf_clr)
    );

    for (genvar p = 0; p < PORT_NUM; p++) begin : gen_alu
        int_alu alu_i (
            .clk (clk), .rst (rst), .i_op (exe_op[p]), .o_fwd (alu_fwd[p]), .o_wb (o_wb[p])
        );
    end

endmodule

// ==== hw/int_alu.sv ====
`timescale 1ns/1ps

module int_alu import iq_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  exe_op_t i_op,
    output wb_t     o_fwd,
    output wb_t     o_wb
);

    xdata_t result;

    always_comb begin
        case (i_op.op)
            ALU_ADD: result = i_op.src0 + i_op.src1;
            ALU_SUB: result = i_op.src0 - i_op.src1;
            ALU_AND: result = i_op.src0 & i_op.src1;
            ALU_OR:  result = i_op.src0 | i_op.src1;
            ALU_XOR: result = i_op.src0 ^ i_op.src1;
            // shift amount from the low 5 bits
            ALU_SLL: result = i_op.src0 << i_op.src1[4:0];
            ALU_SRL: result = i_op.src0 >> i_op.src1[4:0];
            default: result = '0;
        endcase
    end

    // execute stage result for back to back consumers
    assign o_fwd.vld = i_op.vld && i_op.rd_wen;
    assign o_fwd.idx = i_op.iprd;
    assign o_fwd.data = result;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_wb.vld <= 1'b0;
        end else begin
            o_wb <= o_fwd;
        end
    end

endmodule

// ==== hw/reg_read.sv ====
`timescale 1ns/1ps

module reg_read import iq_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [PORT_NUM-1:0] i_iss_vld,
    input  iq_idx_t             i_iss_idx [PORT_NUM],
    input  exe_info_t           i_iss_info [PORT_NUM],
    output logic [PORT_NUM-1:0] o_fin_vec,
    output logic [PORT_NUM-1:0] o_rpl_vec,
    output iq_idx_t             o_fb_idx [PORT_NUM],
    output preg_idx_t           o_prf_rd_idx [RD_NUM],
    input  xdata_t              i_prf_data [RD_NUM],
    input  logic [RD_NUM-1:0]   i_prf_written,
    input  wb_t                 i_alu_fwd [PORT_NUM],
    input  wb_t                 i_alu_wb [PORT_NUM],
    input  wb_t                 i_ld_wb,
    output exe_op_t             o_exe_op [PORT_NUM]
);

    logic [NUM_SRCS-1:0] src_hit [PORT_NUM];
    xdata_t src_val [PORT_NUM][NUM_SRCS];

    // later checks override earlier ones, so execute has the highest priority
    always_comb begin
        preg_idx_t idx;
        for (int p = 0; p < PORT_NUM; p++) begin
            for (int s = 0; s < NUM_SRCS; s++) begin
                idx = src_idx(i_iss_info[p], s);
                o_prf_rd_idx[p*NUM_SRCS+s] = idx;
                src_hit[p][s] = i_prf_written[p*NUM_SRCS+s];
                src_val[p][s] = i_prf_data[p*NUM_SRCS+s];
                if (i_ld_wb.vld && (i_ld_wb.idx == idx)) begin
                    src_hit[p][s] = 1'b1;
                    src_val[p][s] = i_ld_wb.data;
                end
                for (int a = 0; a < PORT_NUM; a++) begin
                    if (i_alu_wb[a].vld && (i_alu_wb[a].idx == idx)) begin
                        src_hit[p][s] = 1'b1;
                        src_val[p][s] = i_alu_wb[a].data;
                    end
                end
                for (int a = 0; a < PORT_NUM; a++) begin
                    if (i_alu_fwd[a].vld && (i_alu_fwd[a].idx == idx)) begin
                        src_hit[p][s] = 1'b1;
                        src_val[p][s] = i_alu_fwd[a].data;
                    end
                end
            end
            o_fin_vec[p] = i_iss_vld[p] && (&src_hit[p]);
            o_rpl_vec[p] = i_iss_vld[p] && !(&src_hit[p]);
            o_fb_idx[p] = i_iss_idx[p];
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < PORT_NUM; p++) begin
            if (rst) begin
                o_exe_op[p].vld <= 1'b0;
            end else begin
                o_exe_op[p] <= '{vld: o_fin_vec[p], op: i_iss_info[p].op,
                                 rd_wen: i_iss_info[p].rd_wen, iprd: i_iss_info[p].iprd,
                                 src0: src_val[p][0], src1: src_val[p][1]};
            end
        end
    end

endmodule

// ==== hw/prf.sv ====
`timescale 1ns/1ps

module prf import iq_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  preg_idx_t         i_rd_idx [RD_NUM],
    output xdata_t            o_rd_data [RD_NUM],
    output logic [RD_NUM-1:0] o_rd_written,
    input  wb_t               i_wr [WB_NUM],
    // destinations that get a new producer
    input  wakeup_t           i_clr [WB_NUM]
);

    xdata_t regs [PREG_NUM];
    logic [PREG_NUM-1:0] written;

    always_comb begin
        for (int r = 0; r < RD_NUM; r++) begin
            o_rd_data[r] = regs[i_rd_idx[r]];
            o_rd_written[r] = written[i_rd_idx[r]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            written <= '1;
        end else begin
            for (int c = 0; c < WB_NUM; c++) begin
                if (i_clr[c].vld) begin
                    written[i_clr[c].idx] <= 1'b0;
                end
            end
            // a write wins over a clear
            for (int w = 0; w < WB_NUM; w++) begin
                if (i_wr[w].vld) begin
                    written[i_wr[w].idx] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < WB_NUM; w++) begin
            if (i_wr[w].vld) begin
                regs[i_wr[w].idx] <= i_wr[w].data;
            end
        end
    end

endmodule

// ==== issue_queue/issue_queue.sv ====
`timescale 1ns/1ps

module issue_queue import iq_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    // enqueue from rename
    input  logic [PORT_NUM-1:0] i_enq_vld,
    input  exe_info_t           i_enq_info [PORT_NUM],
    input  src_vec_t            i_enq_rdy [PORT_NUM],
    output logic                o_enq_ready,
    // issue towards register read
    output logic [PORT_NUM-1:0] o_iss_vld,
    output iq_idx_t             o_iss_idx [PORT_NUM],
    output exe_info_t           o_iss_info [PORT_NUM],
    // feedback from register read
    input  logic [PORT_NUM-1:0] i_fin_vec,
    input  logic [PORT_NUM-1:0] i_rpl_vec,
    input  iq_idx_t             i_fb_idx [PORT_NUM],
    // wakeups
    output wakeup_t             o_int_wakeup [PORT_NUM],
    input  wakeup_t             i_ld_spec,
    input  wb_t                 i_wb [WB_NUM]
);

    iq_entry_t entries [IQ_DEPTH];

    logic [IQ_DEPTH-1:0] entry_vld;
    logic [IQ_DEPTH-1:0] entry_ready;
    logic [PORT_NUM-1:0] free_found;
    logic [PORT_NUM-1:0] sel_found;
    logic [PORT_NUM-1:0] enq_fire;
    iq_idx_t free_idx [PORT_NUM];
    iq_idx_t sel_idx [PORT_NUM];

    // speculative sources: internal wakeups first, then the load
    wakeup_t spec_wk [WB_NUM];

    src_vec_t nxt_src_rdy [IQ_DEPTH];
    src_vec_t nxt_spec_rdy [IQ_DEPTH];
    src_vec_t enq_src_rdy [PORT_NUM];
    src_vec_t enq_spec_rdy [PORT_NUM];

    // sources of an op matched by the writebacks or by the speculative wakeups
    function automatic src_vec_t src_hits(input exe_info_t info, input logic from_wb);
        src_vec_t hits;
        wakeup_t wk;
        hits = '0;
        for (int s = 0; s < NUM_SRCS; s++) begin
            for (int w = 0; w < WB_NUM; w++) begin
                if (from_wb) begin
                    wk.vld = i_wb[w].vld;
                    wk.idx = i_wb[w].idx;
                end else begin
                    wk = spec_wk[w];
                end
                if (wk.vld && (wk.idx == src_idx(info, s))) begin
                    hits[s] = 1'b1;
                end
            end
        end
        return hits;
    endfunction

    iq_select select_i (
        .i_entry_vld   (entry_vld),
        .i_entry_ready (entry_ready),
        .o_free_found  (free_found),
        .o_free_idx    (free_idx),
        .o_sel_found   (sel_found),
        .o_sel_idx     (sel_idx)
    );

    // only accept when both slots have room
    assign o_enq_ready = &free_found;
    assign enq_fire = i_enq_vld & {PORT_NUM{o_enq_ready}};

    always_comb begin
        for (int e = 0; e < IQ_DEPTH; e++) begin
            entry_vld[e] = entries[e].vld;
            entry_ready[e] = entries[e].vld && !entries[e].issued
                && (&(entries[e].src_rdy | entries[e].src_spec_rdy));
        end
    end

    // selected producers wake their consumers in the select cycle
    always_comb begin
        for (int p = 0; p < PORT_NUM; p++) begin
            o_int_wakeup[p].vld = sel_found[p] && entries[sel_idx[p]].info.rd_wen;
            o_int_wakeup[p].idx = entries[sel_idx[p]].info.iprd;
            spec_wk[p] = o_int_wakeup[p];
        end
        spec_wk[PORT_NUM] = i_ld_spec;
    end

    always_comb begin
        for (int e = 0; e < IQ_DEPTH; e++) begin
            nxt_src_rdy[e] = entries[e].src_rdy | src_hits(entries[e].info, 1'b1);
            nxt_spec_rdy[e] = entries[e].src_spec_rdy | nxt_src_rdy[e]
                | src_hits(entries[e].info, 1'b0);
        end
        // incoming ops also catch wakeups of their own cycle
        for (int p = 0; p < PORT_NUM; p++) begin
            enq_src_rdy[p] = i_enq_rdy[p] | src_hits(i_enq_info[p], 1'b1);
            enq_spec_rdy[p] = enq_src_rdy[p] | src_hits(i_enq_info[p], 1'b0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_iss_vld <= '0;
            for (int e = 0; e < IQ_DEPTH; e++) begin
                entries[e].vld <= 1'b0;
            end
        end else begin
            o_iss_vld <= sel_found;
            for (int e = 0; e < IQ_DEPTH; e++) begin
                if (entries[e].vld) begin
                    entries[e].src_rdy <= nxt_src_rdy[e];
                    entries[e].src_spec_rdy <= nxt_spec_rdy[e];
                end
            end
            for (int p = 0; p < PORT_NUM; p++) begin
                if (enq_fire[p]) begin
                    entries[free_idx[p]] <= '{vld: 1'b1, issued: 1'b0,
                                              src_rdy: enq_src_rdy[p],
                                              src_spec_rdy: enq_spec_rdy[p],
                                              info: i_enq_info[p]};
                end
                if (sel_found[p]) begin
                    entries[sel_idx[p]].issued <= 1'b1;
                end
                if (i_fin_vec[p]) begin
                    entries[i_fb_idx[p]].vld <= 1'b0;
                end else if (i_rpl_vec[p]) begin
                    // back to confirmed readiness only
                    entries[i_fb_idx[p]].issued <= 1'b0;
                    entries[i_fb_idx[p]].src_spec_rdy <= nxt_src_rdy[i_fb_idx[p]];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < PORT_NUM; p++) begin
            o_iss_idx[p] <= sel_idx[p];
            o_iss_info[p] <= entries[sel_idx[p]].info;
        end
    end

endmodule

// ==== issue_queue/iq_select.sv ====
`timescale 1ns/1ps

module iq_select import iq_pkg::*; (
    input  logic [IQ_DEPTH-1:0] i_entry_vld,
    input  logic [IQ_DEPTH-1:0] i_entry_ready,
    output logic [PORT_NUM-1:0] o_free_found,
    output iq_idx_t             o_free_idx [PORT_NUM],
    output logic [PORT_NUM-1:0] o_sel_found,
    output iq_idx_t             o_sel_idx [PORT_NUM]
);

    // lowest set bit, found flag on top
    function automatic logic [IQ_IDX_W:0] find_low(input logic [IQ_DEPTH-1:0] mask);
        logic [IQ_IDX_W:0] res;
        res = '0;
        for (int e = IQ_DEPTH - 1; e >= 0; e--) begin
            if (mask[e]) begin
                res = {1'b1, iq_idx_t'(e)};
            end
        end
        return res;
    endfunction

    always_comb begin
        logic [IQ_DEPTH-1:0] free_mask;
        logic [IQ_DEPTH-1:0] rdy_mask;
        logic [IQ_IDX_W:0] free_hit;
        logic [IQ_IDX_W:0] sel_hit;
        free_mask = ~i_entry_vld;
        rdy_mask = i_entry_ready;
        for (int p = 0; p < PORT_NUM; p++) begin
            free_hit = find_low(free_mask);
            sel_hit = find_low(rdy_mask);
            o_free_found[p] = free_hit[IQ_IDX_W];
            o_free_idx[p] = free_hit[IQ_IDX_W-1:0];
            o_sel_found[p] = sel_hit[IQ_IDX_W];
            o_sel_idx[p] = sel_hit[IQ_IDX_W-1:0];
            // next port sees the remaining entries only
            if (free_hit[IQ_IDX_W]) begin
                free_mask[free_hit[IQ_IDX_W-1:0]] = 1'b0;
            end
            if (sel_hit[IQ_IDX_W]) begin
                rdy_mask[sel_hit[IQ_IDX_W-1:0]] = 1'b0;
            end
        end
    end

endmodule

// ==== common/iq_pkg.sv ====
package iq_pkg;

    // queue and port sizes
    localparam int IQ_DEPTH = 8;
    localparam int PORT_NUM = 2;
    localparam int NUM_SRCS = 2;
    localparam int PREG_NUM = 64;
    localparam int IQ_IDX_W = 3;
    localparam int PREG_IDX_W = 6;
    localparam int XLEN = 32;

    // two ALU writebacks plus the load, also the speculative wakeup count
    localparam int WB_NUM = PORT_NUM + 1;
    // register file read ports, one per source per issue port
    localparam int RD_NUM = PORT_NUM * NUM_SRCS;

    typedef logic [PREG_IDX_W-1:0] preg_idx_t;
    typedef logic [IQ_IDX_W-1:0] iq_idx_t;
    typedef logic [XLEN-1:0] xdata_t;
    typedef logic [NUM_SRCS-1:0] src_vec_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL
    } alu_op_t;

    typedef struct packed {
        alu_op_t op;
        preg_idx_t iprs0;
        preg_idx_t iprs1;
        preg_idx_t iprd;
        logic rd_wen;
    } exe_info_t;

    typedef struct packed {
        logic vld;
        logic issued;
        src_vec_t src_rdy;
        // ready through a wakeup that may still be wrong
        src_vec_t src_spec_rdy;
        exe_info_t info;
    } iq_entry_t;

    typedef struct packed {
        logic vld;
        preg_idx_t idx;
    } wakeup_t;

    typedef struct packed {
        logic vld;
        preg_idx_t idx;
        xdata_t data;
    } wb_t;

    typedef struct packed {
        logic vld;
        alu_op_t op;
        logic rd_wen;
        preg_idx_t iprd;
        xdata_t src0;
        xdata_t src1;
    } exe_op_t;

    // physical source index by source number
    function automatic preg_idx_t src_idx(input exe_info_t info, input int unsigned s);
        return (s == 0) ? info.iprs0 : info.iprs1;
    endfunction

endpackage
